// File: Makefile
# Verilator build and run for the branch order buffer testbench.

VERILATOR ?= verilator
TOP ?= bob_tb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert -Wno-fatal
PASS_TEXT ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: common/bob_pkg.sv
`default_nettype none

package bob_pkg;

  // Buffer geometry, fixed by the core's tag space.
  localparam int bob_count = 48;
  localparam int bob_last = 47; // Pointers wrap here.
  localparam int bob_addr_width = 6;

  // Outcome word: {mispredict, taken, target}.
  localparam int bob_target_width = 30; // Word address.
  localparam int bob_flags_width = 2;
  localparam int bob_data_width = 32;

  // Flag positions inside the RAM word.
  localparam int bob_taken_bit = bob_target_width;
  localparam int bob_mispredict_bit = bob_target_width + 1;

endpackage

`default_nettype wire

// File: common/bob_wr_if.sv
`default_nettype none

// Resolved outcome heading for the RAM.
interface bob_wr_if;
  import bob_pkg::*;

  logic wen;
  logic [bob_addr_width-1:0] addr;
  logic [bob_target_width-1:0] target;
  logic [bob_flags_width-1:0] flags; // {mispredict, taken}

  modport src (
    output wen,
    output addr,
    output target,
    output flags
  );

  modport dst (
    input wen,
    input addr,
    input target,
    input flags
  );

endinterface

`default_nettype wire

// File: hw/bob/bob_addr.sv
`default_nettype none

module bob_addr (
  input  logic clk,
  input  logic rst,
  input  logic flush,
  input  logic alloc_en,
  output logic [bob_pkg::bob_addr_width-1:0] alloc_tag,
  output logic full,
  input  logic do_retire,
  output logic has_retire,
  output logic [bob_pkg::bob_addr_width-1:0] retire_addr
);
  import bob_pkg::*;

  logic [bob_addr_width-1:0] alloc_ptr;
  logic [bob_addr_width-1:0] retire_ptr;
  logic [bob_addr_width-1:0] count; // 0 to 48.
  logic alloc;

  function automatic logic [bob_addr_width-1:0] next_tag(
    input logic [bob_addr_width-1:0] tag
  );
    return (tag == bob_addr_width'(bob_last)) ? '0 : tag + 1'b1;
  endfunction

  assign full = (count == bob_addr_width'(bob_count));
  assign has_retire = (count != '0);
  assign alloc = alloc_en && !full; // Held off while full.

  assign alloc_tag = alloc_ptr;
  assign retire_addr = retire_ptr;

  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_ptr <= '0;
      retire_ptr <= '0;
      count <= '0;
    end else if (flush) begin
      // Everything in flight is dropped.
      retire_ptr <= alloc_ptr;
      count <= '0;
    end else begin
      if (alloc) begin
        alloc_ptr <= next_tag(alloc_ptr);
      end
      if (do_retire) begin
        retire_ptr <= next_tag(retire_ptr);
      end
      case ({alloc, do_retire})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count; // Both or neither.
      endcase
    end
  end

  // Occupancy stays within the tag space.
  a_count_bound: assert property (
    @(posedge clk) disable iff (rst)
    count <= bob_count
  ) else $error("bob_addr: count %0d above depth", count);

  // The retire stage only pops a non-empty buffer.
  a_retire_nonempty: assert property (
    @(posedge clk) disable iff (rst)
    do_retire |-> has_retire
  ) else $error("bob_addr: retire with empty buffer");

endmodule

`default_nettype wire

// File: hw/bob/bob_ram.sv
`default_nettype none

module bob_ram (
  input  logic clk,
  input  logic read_clk_en,
  input  logic [bob_pkg::bob_addr_width-1:0] read_addr,
  output logic [bob_pkg::bob_data_width-1:0] read_data,
  bob_wr_if.dst wr
);
  import bob_pkg::*;

  logic [bob_data_width-1:0] mem [bob_count];
  logic [bob_addr_width-1:0] read_addr_q;

  always_ff @(posedge clk) begin
    if (wr.wen) begin
      mem[wr.addr] <= {wr.flags, wr.target};
    end
    // Address only moves on a retirement, so the output holds between them.
    if (read_clk_en) begin
      read_addr_q <= read_addr;
    end
  end

  assign read_data = mem[read_addr_q];

endmodule

`default_nettype wire

// File: hw/bob/bob_resolve.sv
`default_nettype none

module bob_resolve (
  input  logic clk,
  input  logic rst,
  input  logic flush,
  input  logic resolve_en,
  input  logic [bob_pkg::bob_addr_width-1:0] resolve_tag,
  input  logic [bob_pkg::bob_target_width-1:0] resolve_target,
  input  logic resolve_taken,
  input  logic resolve_mispredict,
  input  logic do_retire,
  input  logic [bob_pkg::bob_addr_width-1:0] head_tag,
  output logic head_done,
  bob_wr_if.src wr
);
  import bob_pkg::*;

  logic pend_valid;
  logic [bob_addr_width-1:0] pend_tag;
  logic [bob_target_width-1:0] pend_target;
  logic [bob_flags_width-1:0] pend_flags;
  logic [bob_count-1:0] done; // One bit per tag.

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      pend_valid <= 1'b0;
    end else begin
      pend_valid <= resolve_en;
    end
    pend_tag <= resolve_tag;
    pend_target <= resolve_target;
    pend_flags <= {resolve_mispredict, resolve_taken};
  end

  // Write lands together with the done bit.
  assign wr.wen = pend_valid && !flush;
  assign wr.addr = pend_tag;
  assign wr.target = pend_target;
  assign wr.flags = pend_flags;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      done <= '0;
    end else begin
      if (do_retire) begin
        done[head_tag] <= 1'b0;
      end
      if (pend_valid) begin
        done[pend_tag] <= 1'b1;
      end
    end
  end

  assign head_done = done[head_tag];

  // Each branch resolves once between allocation and retirement.
  a_single_resolve: assert property (
    @(posedge clk) disable iff (rst)
    (pend_valid && !flush) |-> !done[pend_tag]
  ) else $error("bob_resolve: tag %0d resolved twice", pend_tag);

endmodule

`default_nettype wire

// File: hw/bob/bob_retire.sv
`default_nettype none

module bob_retire (
  input  logic clk,
  input  logic rst,
  input  logic flush,
  input  logic has_retire,
  input  logic [bob_pkg::bob_addr_width-1:0] head_tag,
  input  logic head_done,
  output logic do_retire,
  output logic read_clk_en,
  output logic [bob_pkg::bob_addr_width-1:0] read_addr,
  input  logic [bob_pkg::bob_data_width-1:0] read_data,
  output logic retire_valid,
  output logic [bob_pkg::bob_addr_width-1:0] retire_tag,
  output logic [bob_pkg::bob_target_width-1:0] retire_target,
  output logic retire_taken,
  output logic retire_mispredict
);
  import bob_pkg::*;

  // Oldest branch leaves once resolved.
  assign do_retire = has_retire && head_done && !flush;

  // Head tag becomes the RAM read address on the retiring edge.
  assign read_clk_en = do_retire;
  assign read_addr = head_tag;

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= do_retire; // Low after a flush edge.
    end
  end

  always_ff @(posedge clk) begin
    if (do_retire) begin
      retire_tag <= head_tag;
    end
  end

  // Unpack the outcome word.
  assign retire_target = read_data[bob_target_width-1:0];
  assign retire_taken = read_data[bob_taken_bit];
  assign retire_mispredict = read_data[bob_mispredict_bit];

endmodule

`default_nettype wire

// File: hw/bob_top.sv
`default_nettype none

module bob_top (
  input  logic clk,
  input  logic rst,
  input  logic flush,
  input  logic alloc_en,
  output logic [bob_pkg::bob_addr_width-1:0] alloc_tag,
  output logic full,
  input  logic resolve_en,
  input  logic [bob_pkg::bob_addr_width-1:0] resolve_tag,
  input  logic [bob_pkg::bob_target_width-1:0] resolve_target,
  input  logic resolve_taken,
  input  logic resolve_mispredict,
  output logic retire_valid,
  output logic [bob_pkg::bob_addr_width-1:0] retire_tag,
  output logic [bob_pkg::bob_target_width-1:0] retire_target,
  output logic retire_taken,
  output logic retire_mispredict
);
  import bob_pkg::*;

  logic has_retire;
  logic do_retire;
  logic head_done;
  logic [bob_addr_width-1:0] head_tag;
  logic read_clk_en;
  logic [bob_addr_width-1:0] read_addr;
  logic [bob_data_width-1:0] read_data;

  bob_wr_if wr_bus ();

  bob_addr u_addr (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .alloc_en(alloc_en),
    .alloc_tag(alloc_tag),
    .full(full),
    .do_retire(do_retire),
    .has_retire(has_retire),
    .retire_addr(head_tag)
  );

  bob_resolve u_resolve (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .resolve_en(resolve_en),
    .resolve_tag(resolve_tag),
    .resolve_target(resolve_target),
    .resolve_taken(resolve_taken),
    .resolve_mispredict(resolve_mispredict),
    .do_retire(do_retire),
    .head_tag(head_tag),
    .head_done(head_done),
    .wr(wr_bus.src)
  );

  bob_ram u_ram (
    .clk(clk),
    .read_clk_en(read_clk_en),
    .read_addr(read_addr),
    .read_data(read_data),
    .wr(wr_bus.dst)
  );

  bob_retire u_retire (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .has_retire(has_retire),
    .head_tag(head_tag),
    .head_done(head_done),
    .do_retire(do_retire),
    .read_clk_en(read_clk_en),
    .read_addr(read_addr),
    .read_data(read_data),
    .retire_valid(retire_valid),
    .retire_tag(retire_tag),
    .retire_target(retire_target),
    .retire_taken(retire_taken),
    .retire_mispredict(retire_mispredict)
  );

endmodule

`default_nettype wire

// File: verification/bob_checker.sv
`default_nettype none

module bob_checker (
  input  logic clk,
  input  logic rst,
  input  logic flush,
  input  logic alloc_en,
  input  logic [bob_pkg::bob_addr_width-1:0] alloc_tag,
  input  logic full,
  input  logic resolve_en,
  input  logic [bob_pkg::bob_addr_width-1:0] resolve_tag,
  input  logic [bob_pkg::bob_target_width-1:0] resolve_target,
  input  logic resolve_taken,
  input  logic resolve_mispredict,
  input  logic retire_valid,
  input  logic [bob_pkg::bob_addr_width-1:0] retire_tag,
  input  logic [bob_pkg::bob_target_width-1:0] retire_target,
  input  logic retire_taken,
  input  logic retire_mispredict,
  output int errors,
  output int checks,
  output int retired,
  output logic idle
);
  import bob_pkg::*;

  logic [bob_addr_width-1:0] live_q [$]; // Tags in allocation order.
  logic [bob_addr_width-1:0] next_alloc;
  logic res_done [bob_count];
  logic [bob_target_width-1:0] res_target [bob_count];
  logic [1:0] res_flags [bob_count]; // {mispredict, taken}
  logic pend_valid;
  logic [bob_addr_width-1:0] pend_tag;
  logic [bob_target_width-1:0] pend_target;
  logic [1:0] pend_flags;
  logic exp_valid;
  logic [bob_addr_width-1:0] exp_tag;
  logic [bob_target_width-1:0] exp_target;
  logic [1:0] exp_flags;

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic logic tag_in_flight(input logic [bob_addr_width-1:0] tag);
    foreach (live_q[i]) begin
      if (live_q[i] == tag) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Outputs are compared mid-cycle, then the model takes the coming edge.
  always @(negedge clk) begin : model
    logic do_ret;
    logic take_alloc;
    if (rst) begin
      live_q.delete();
      foreach (res_done[i]) res_done[i] = 1'b0;
      next_alloc = '0;
      pend_valid = 1'b0;
      exp_valid = 1'b0;
      errors = 0;
      checks = 0;
      retired = 0;
    end else begin
      check_value("alloc_tag", 32'(alloc_tag), 32'(next_alloc));
      check_value("full", 32'(full), 32'(live_q.size() == bob_count));
      check_value("retire_valid", 32'(retire_valid), 32'(exp_valid));
      if (exp_valid) begin
        retired++;
        check_value("retire_tag", 32'(retire_tag), 32'(exp_tag));
        check_value("retire_target", 32'(retire_target), 32'(exp_target));
        check_value("retire_taken", 32'(retire_taken), 32'(exp_flags[0]));
        check_value("retire_mispredict", 32'(retire_mispredict), 32'(exp_flags[1]));
      end
      if (resolve_en && !tag_in_flight(resolve_tag)) begin
        errors++;
        $display("Resolve of tag %0d that is not in flight at %0t", resolve_tag, $time);
      end

      do_ret = (live_q.size() != 0) && res_done[live_q[0]] && !flush;
      take_alloc = alloc_en && (live_q.size() < bob_count);
      if (flush) begin
        // Everything in flight is gone. The allocation tag stays.
        live_q.delete();
        foreach (res_done[i]) res_done[i] = 1'b0;
        pend_valid = 1'b0;
        exp_valid = 1'b0;
      end else begin
        exp_valid = do_ret;
        if (do_ret) begin
          exp_tag = live_q.pop_front();
          exp_target = res_target[exp_tag];
          exp_flags = res_flags[exp_tag];
          res_done[exp_tag] = 1'b0;
        end
        if (pend_valid) begin
          res_done[pend_tag] = 1'b1;
          res_target[pend_tag] = pend_target;
          res_flags[pend_tag] = pend_flags;
        end
        pend_valid = resolve_en; // Lands one edge later.
        pend_tag = resolve_tag;
        pend_target = resolve_target;
        pend_flags = {resolve_mispredict, resolve_taken};
        if (take_alloc) begin
          live_q.push_back(next_alloc);
          next_alloc = (next_alloc == bob_addr_width'(bob_count - 1)) ? '0 : next_alloc + 1'b1;
        end
      end
    end
    idle = (live_q.size() == 0) && !pend_valid && !exp_valid;
  end

endmodule

`default_nettype wire

// File: verification/bob_tb.sv
`default_nettype none

module bob_tb;
  import bob_pkg::*;

  localparam int max_rows = 600;
  localparam int random_rows = 300;
  localparam int timeout_margin = 200;
  localparam logic [31:0] seed = 32'hf9279b5b;

  logic clk;
  logic rst;
  logic flush;
  logic alloc_en;
  logic [bob_addr_width-1:0] alloc_tag;
  logic full;
  logic resolve_en;
  logic [bob_addr_width-1:0] resolve_tag;
  logic [bob_target_width-1:0] resolve_target;
  logic resolve_taken;
  logic resolve_mispredict;
  logic retire_valid;
  logic [bob_addr_width-1:0] retire_tag;
  logic [bob_target_width-1:0] retire_target;
  logic retire_taken;
  logic retire_mispredict;
  int errors;
  int checks;
  int retired;
  logic idle;

  // One row per cycle. Payload is {mispredict, taken, target}.
  logic row_alloc [max_rows];
  logic row_res [max_rows];
  int row_idx [max_rows]; // Index into the unresolved tags.
  logic row_flush [max_rows];
  logic [31:0] row_payload [max_rows];
  int n_rows;
  int test_end [8];
  string test_name [8];
  int n_tests;
  int limit;
  int cycles;
  logic [bob_addr_width-1:0] unresolved [$];

  bob_top dut (.*);

  bob_checker chk (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] fixed_payload(input int n);
    return 32'(n) * 32'h2f1b3c45 + 32'h00400000;
  endfunction

  task automatic add_row(input logic alloc, input logic res, input int idx, input logic fl,
                         input logic [31:0] payload);
    row_alloc[n_rows] = alloc;
    row_res[n_rows] = res;
    row_idx[n_rows] = idx;
    row_flush[n_rows] = fl;
    row_payload[n_rows] = payload;
    n_rows++;
  endtask

  task automatic add_rows(input int count, input logic alloc, input logic res, input int step);
    for (int i = 0; i < count; i++) begin
      add_row(alloc, res, i * step, 1'b0, fixed_payload(n_rows));
    end
  endtask

  task automatic end_test(input string name);
    test_name[n_tests] = name;
    test_end[n_tests] = n_rows;
    n_tests++;
  endtask

  task automatic build_table();
    logic [31:0] state;
    logic [31:0] r;
    state = seed;
    add_rows(2, 1'b0, 1'b0, 0);
    end_test("reset");
    add_rows(4, 1'b1, 1'b0, 0);
    add_row(1'b0, 1'b1, 3, 1'b0, fixed_payload(n_rows)); // Youngest first.
    add_row(1'b0, 1'b1, 1, 1'b0, fixed_payload(n_rows));
    add_row(1'b0, 1'b1, 1, 1'b0, fixed_payload(n_rows));
    add_row(1'b0, 1'b1, 0, 1'b0, fixed_payload(n_rows)); // Head unblocks all.
    add_rows(4, 1'b0, 1'b0, 0);
    end_test("in_order");
    add_rows(50, 1'b1, 1'b0, 0); // Last two meet a full buffer.
    add_rows(48, 1'b0, 1'b1, 5);
    add_rows(8, 1'b1, 1'b1, 0);
    end_test("full");
    add_rows(6, 1'b1, 1'b0, 0);
    add_rows(3, 1'b0, 1'b1, 2);
    add_row(1'b1, 1'b1, 0, 1'b1, fixed_payload(n_rows)); // Flush beats alloc.
    add_rows(2, 1'b0, 1'b0, 0);
    add_rows(2, 1'b1, 1'b0, 0);
    add_rows(2, 1'b0, 1'b1, 0);
    add_rows(3, 1'b0, 1'b0, 0);
    end_test("flush");
    for (int i = 0; i < random_rows; i++) begin
      state = next_random(state);
      r = state;
      state = next_random(state);
      add_row(r[31] | r[30], r[29] | r[28], int'(r[21:16]), r[27:22] == 6'd0, state);
    end
    end_test("random");
    add_rows(64, 1'b0, 1'b1, 0);
    end_test("drain");
  endtask

  task automatic report_test(input int t, input int mark);
    $display("Test %s finished with %0d errors", test_name[t], errors - mark);
  endtask

  initial begin
    int t;
    int mark;
    int size;
    int k;
    logic res;
    logic [bob_addr_width-1:0] tag;
    rst = 1'b1;
    flush = 1'b0;
    alloc_en = 1'b0;
    resolve_en = 1'b0;
    resolve_tag = '0;
    resolve_target = '0;
    resolve_taken = 1'b0;
    resolve_mispredict = 1'b0;
    tag = '0;
    t = 0;
    mark = 0;
    build_table();
    limit = n_rows + timeout_margin;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int row = 0; row < n_rows; row++) begin
      @(posedge clk);
      if (row == test_end[t]) begin
        report_test(t, mark);
        mark = errors;
        t++;
      end
      size = unresolved.size();
      res = row_res[row] && (size != 0);
      if (res) begin
        k = row_idx[row] % size;
        tag = unresolved[k];
        unresolved.delete(k);
      end
      alloc_en <= row_alloc[row];
      resolve_en <= res;
      resolve_tag <= tag;
      resolve_target <= row_payload[row][bob_target_width-1:0];
      resolve_taken <= row_payload[row][30];
      resolve_mispredict <= row_payload[row][31];
      flush <= row_flush[row];
      // Allocation outcome is read mid-cycle.
      @(negedge clk);
      if (row_flush[row]) begin
        unresolved.delete();
      end else if (row_alloc[row] && !full) begin
        unresolved.push_back(alloc_tag);
      end
    end
    @(posedge clk);
    alloc_en <= 1'b0;
    resolve_en <= 1'b0;
    flush <= 1'b0;
    while (!idle) @(posedge clk);
    report_test(t, mark);
    if (retired == 0) begin
      $display("No branch retired during the run");
    end
    $display("Summary: %0d tests, %0d checks, %0d retired, %0d errors",
             n_tests, checks, retired, errors);
    if (errors == 0 && retired != 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    wait (limit != 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
common/bob_pkg.sv
common/bob_wr_if.sv
hw/bob/bob_ram.sv
hw/bob/bob_addr.sv
hw/bob/bob_resolve.sv
hw/bob/bob_retire.sv
hw/bob_top.sv
verification/bob_checker.sv
verification/bob_tb.sv
